//--- include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and address width
`define CPU_XLEN 32

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// Integer register file
`define CPU_NREGS 32
`define CPU_REG_BITS 5

// Width of bresp on the AXI-Lite port
`define CPU_AXI_RESP_W 2

`endif

//--- hdl/cpu_isa_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_isa_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef logic [`CPU_REG_BITS-1:0] reg_idx_t;

    typedef struct packed {
        opcode_e                opcode;
        alu_op_e                alu_op;
        reg_idx_t               rd;
        reg_idx_t               rs1;
        reg_idx_t               rs2;
        logic                   rd_we;
        logic [`CPU_XLEN-1:0]   imm;
        logic                   use_imm;
        logic                   pc_opt;
        logic [`CPU_XLEN-1:0]   pc;
    } decoded_t;

    // Pending write and PC change that a later stage still owes
    typedef struct packed {
        logic     we;
        reg_idx_t idx;
        logic     pc_opt;
    } rd_tag_t;

endpackage

`default_nettype wire

//--- hdl/cpu_bus_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_bus_pkg;

    typedef struct packed {
        logic [`CPU_XLEN-1:0]   araddr;
        logic                   arvalid;
        logic                   rready;
        logic [`CPU_XLEN-1:0]   awaddr;
        logic                   awvalid;
        logic [`CPU_XLEN-1:0]   wdata;
        logic [`CPU_XLEN/8-1:0] wstrb;
        logic                   wvalid;
        logic                   bready;
    } axi_req_t;

    typedef struct packed {
        logic                       arready;
        logic [`CPU_XLEN-1:0]       rdata;
        logic                       rvalid;
        logic                       awready;
        logic                       wready;
        logic [`CPU_AXI_RESP_W-1:0] bresp;
        logic                       bvalid;
    } axi_rsp_t;

    // Request that the requester holds until done
    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [`CPU_XLEN-1:0] addr;
        logic [`CPU_XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 done;
        logic [`CPU_XLEN-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- hdl/reg_file.sv
`default_nettype none

`include "cpu_settings.svh"

module reg_file (
    input  wire                           clk,
    input  wire                           reset,
    input  wire logic [`CPU_REG_BITS-1:0] rs1_index,
    input  wire logic [`CPU_REG_BITS-1:0] rs2_index,
    output logic [`CPU_XLEN-1:0]          rs1_data,
    output logic [`CPU_XLEN-1:0]          rs2_data,
    input  wire                           we,
    input  wire logic [`CPU_REG_BITS-1:0] rd_index,
    input  wire logic [`CPU_XLEN-1:0]     rd_data
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_index != '0) begin
            regs[rd_index] <= rd_data;
        end
    end

    assign rs1_data = (rs1_index == '0) ? '0 : regs[rs1_index];
    assign rs2_data = (rs2_index == '0) ? '0 : regs[rs2_index];

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`default_nettype none

`include "cpu_settings.svh"

module fetch_unit
    import cpu_bus_pkg::*;
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       hold,
    input  wire                       redirect_valid,
    input  wire logic [`CPU_XLEN-1:0] redirect_pc,
    output logic                      if_valid,
    input  wire                       if_ready,
    output logic [`CPU_XLEN-1:0]      inst,
    output logic [`CPU_XLEN-1:0]      inst_pc,
    output mem_req_t                  ifetch_req,
    input  wire mem_rsp_t             ifetch_rsp
);

    logic [`CPU_XLEN-1:0] pc;
    logic                 busy;
    logic                 room;

    // The output register is empty by the time done arrives
    assign room = !if_valid || if_ready;

    assign ifetch_req.valid = busy;
    assign ifetch_req.write = 1'b0;
    assign ifetch_req.addr  = pc;
    assign ifetch_req.wdata = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= `CPU_RESET_PC;
            busy     <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            if (redirect_valid) begin
                pc <= redirect_pc;
            end else if (ifetch_rsp.done) begin
                pc <= pc + `CPU_XLEN'(4);
            end
            if (ifetch_rsp.done) begin
                busy <= 1'b0;
            end else if (!busy && room && !hold) begin
                busy <= 1'b1;
            end
            if (ifetch_rsp.done) begin
                if_valid <= 1'b1;
            end else if (if_ready) begin
                if_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ifetch_rsp.done) begin
            inst    <= ifetch_rsp.rdata;
            inst_pc <= pc;
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode_unit.sv
`default_nettype none

`include "cpu_settings.svh"

module decode_unit
    import cpu_isa_pkg::*;
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       if_valid,
    output logic                      if_ready,
    input  wire logic [`CPU_XLEN-1:0] inst,
    input  wire logic [`CPU_XLEN-1:0] inst_pc,
    output reg_idx_t                  rs1_index,
    output reg_idx_t                  rs2_index,
    input  wire logic [`CPU_XLEN-1:0] rs1_data,
    input  wire logic [`CPU_XLEN-1:0] rs2_data,
    input  wire rd_tag_t              ex_rd,
    input  wire rd_tag_t              me_rd,
    output logic                      hold,
    output logic                      id_valid,
    input  wire                       id_ready,
    output decoded_t                  id_item,
    output logic [`CPU_XLEN-1:0]      rs1_val,
    output logic [`CPU_XLEN-1:0]      rs2_val
);

    decoded_t dec;
    rd_tag_t  own;
    logic     use_rs1;
    logic     use_rs2;
    logic     conflict;

    function automatic alu_op_e alu_sel(input logic [2:0] funct3, input logic sub);
        case (funct3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    function automatic logic pending(input rd_tag_t tag, input reg_idx_t idx);
        return tag.we && tag.idx == idx;
    endfunction

    always_comb begin
        dec        = '0;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        dec.opcode = opcode_e'(inst[6:0]);
        dec.alu_op = ALU_ADD;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.pc     = inst_pc;
        case (dec.opcode)
            OPC_OP: begin
                dec.alu_op = alu_sel(inst[14:12], inst[30]);
                dec.rd_we  = 1'b1;
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
            end
            OPC_OP_IMM: begin
                dec.alu_op  = alu_sel(inst[14:12], 1'b0);
                dec.imm     = {{20{inst[31]}}, inst[31:20]};
                dec.use_imm = 1'b1;
                dec.rd_we   = 1'b1;
                use_rs1     = 1'b1;
            end
            OPC_LUI: begin
                dec.alu_op  = ALU_PASS_B;
                dec.imm     = {inst[31:12], 12'b0};
                dec.use_imm = 1'b1;
                dec.rd_we   = 1'b1;
            end
            OPC_LOAD: begin
                dec.imm     = {{20{inst[31]}}, inst[31:20]};
                dec.use_imm = 1'b1;
                dec.rd_we   = 1'b1;
                use_rs1     = 1'b1;
            end
            OPC_STORE: begin
                dec.imm     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                dec.use_imm = 1'b1;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
            end
            OPC_BRANCH: begin
                dec.alu_op = ALU_SUB;
                dec.imm    = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                dec.pc_opt = 1'b1;
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
            end
            OPC_JAL: begin
                dec.imm    = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                dec.pc_opt = 1'b1;
                dec.rd_we  = 1'b1;
            end
            default: ;
        endcase
        // x0 is never a real destination
        if (dec.rd == '0) begin
            dec.rd_we = 1'b0;
        end
    end

    assign own.we     = id_valid && id_item.rd_we;
    assign own.idx    = id_item.rd;
    assign own.pc_opt = id_valid && id_item.pc_opt;

    assign conflict = (use_rs1 && (pending(own, dec.rs1) || pending(ex_rd, dec.rs1)
                                   || pending(me_rd, dec.rs1)))
                   || (use_rs2 && (pending(own, dec.rs2) || pending(ex_rd, dec.rs2)
                                   || pending(me_rd, dec.rs2)));

    // Fetch waits until the PC-changing instruction leaves memory
    assign hold = (if_valid && dec.pc_opt) || own.pc_opt || ex_rd.pc_opt || me_rd.pc_opt;

    assign rs1_index = dec.rs1;
    assign rs2_index = dec.rs2;
    assign if_ready  = !conflict && (!id_valid || id_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (if_valid && if_ready) begin
            id_valid <= 1'b1;
        end else if (id_ready) begin
            id_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && if_ready) begin
            id_item <= dec;
            rs1_val <= rs1_data;
            rs2_val <= rs2_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/execute_unit.sv
`default_nettype none

`include "cpu_settings.svh"

module execute_unit
    import cpu_isa_pkg::*;
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       id_valid,
    output logic                      id_ready,
    input  wire decoded_t             id_item,
    input  wire logic [`CPU_XLEN-1:0] rs1_val,
    input  wire logic [`CPU_XLEN-1:0] rs2_val,
    output logic                      ex_valid,
    input  wire                       ex_ready,
    output decoded_t                  ex_item,
    output logic [`CPU_XLEN-1:0]      ex_result,
    output logic [`CPU_XLEN-1:0]      ex_store_data,
    output logic [`CPU_XLEN-1:0]      ex_target,
    output logic                      ex_taken,
    output rd_tag_t                   ex_rd
);

    logic [`CPU_XLEN-1:0] op_b;
    logic [`CPU_XLEN-1:0] alu_res;

    assign op_b = id_item.use_imm ? id_item.imm : rs2_val;

    always_comb begin
        case (id_item.alu_op)
            ALU_SUB:    alu_res = rs1_val - op_b;
            ALU_AND:    alu_res = rs1_val & op_b;
            ALU_OR:     alu_res = rs1_val | op_b;
            ALU_XOR:    alu_res = rs1_val ^ op_b;
            ALU_SLT:    alu_res = ($signed(rs1_val) < $signed(op_b)) ? `CPU_XLEN'(1) : '0;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = rs1_val + op_b;
        endcase
    end

    assign id_ready = !ex_valid || ex_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (id_valid && id_ready) begin
            ex_valid <= 1'b1;
        end else if (ex_ready) begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid && id_ready) begin
            ex_item       <= id_item;
            // JAL links PC+4 into rd
            ex_result     <= (id_item.opcode == OPC_JAL) ? id_item.pc + `CPU_XLEN'(4) : alu_res;
            ex_store_data <= rs2_val;
            ex_target     <= id_item.pc + id_item.imm;
            ex_taken      <= (id_item.opcode == OPC_JAL)
                          || (id_item.opcode == OPC_BRANCH && alu_res == '0);
        end
    end

    assign ex_rd.we     = ex_valid && ex_item.rd_we;
    assign ex_rd.idx    = ex_item.rd;
    assign ex_rd.pc_opt = ex_valid && ex_item.pc_opt;

endmodule

`default_nettype wire

//--- hdl/mem_unit.sv
`default_nettype none

`include "cpu_settings.svh"

module mem_unit
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       ex_valid,
    output logic                      ex_ready,
    input  wire decoded_t             ex_item,
    input  wire logic [`CPU_XLEN-1:0] ex_result,
    input  wire logic [`CPU_XLEN-1:0] ex_store_data,
    input  wire logic [`CPU_XLEN-1:0] ex_target,
    input  wire                       ex_taken,
    output mem_req_t                  data_req,
    input  wire mem_rsp_t             data_rsp,
    output rd_tag_t                   me_rd,
    output logic                      we,
    output reg_idx_t                  rd_index,
    output logic [`CPU_XLEN-1:0]      rd_data,
    output logic                      redirect_valid,
    output logic [`CPU_XLEN-1:0]      redirect_pc
);

    logic                 me_valid;
    decoded_t             me_item;
    logic [`CPU_XLEN-1:0] me_result;
    logic [`CPU_XLEN-1:0] me_store_data;
    logic [`CPU_XLEN-1:0] me_target;
    logic                 me_taken;
    logic                 is_load;
    logic                 is_mem;
    logic                 me_done;

    assign is_load = me_item.opcode == OPC_LOAD;
    assign is_mem  = is_load || me_item.opcode == OPC_STORE;

    // Loads and stores finish on done and all other items in one cycle
    assign me_done  = me_valid && (!is_mem || data_rsp.done);
    assign ex_ready = !me_valid || me_done;

    assign data_req.valid = me_valid && is_mem;
    assign data_req.write = !is_load;
    assign data_req.addr  = me_result;
    assign data_req.wdata = me_store_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            me_valid <= 1'b0;
        end else if (ex_valid && ex_ready) begin
            me_valid <= 1'b1;
        end else if (me_done) begin
            me_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid && ex_ready) begin
            me_item       <= ex_item;
            me_result     <= ex_result;
            me_store_data <= ex_store_data;
            me_target     <= ex_target;
            me_taken      <= ex_taken;
        end
    end

    assign we       = me_done && me_item.rd_we;
    assign rd_index = me_item.rd;
    assign rd_data  = is_load ? data_rsp.rdata : me_result;

    assign redirect_valid = me_done && me_item.pc_opt;
    assign redirect_pc    = me_taken ? me_target : me_item.pc + `CPU_XLEN'(4);

    assign me_rd.we     = me_valid && me_item.rd_we;
    assign me_rd.idx    = me_item.rd;
    assign me_rd.pc_opt = me_valid && me_item.pc_opt;

endmodule

`default_nettype wire

//--- hdl/bus_arbiter.sv
`default_nettype none

module bus_arbiter
    import cpu_bus_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire mem_req_t ifetch_req,
    output mem_rsp_t      ifetch_rsp,
    input  wire mem_req_t data_req,
    output mem_rsp_t      data_rsp,
    output axi_req_t      axi_req,
    input  wire axi_rsp_t axi_rsp
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        WRESP
    } state_e;

    state_e   state;
    mem_req_t pick;
    mem_req_t cur;
    logic     owner_data;
    logic     ar_done;
    logic     aw_done;
    logic     w_done;
    logic     aw_fire;
    logic     w_fire;
    logic     done;

    assign pick    = data_req.valid ? data_req : ifetch_req;
    assign aw_fire = axi_req.awvalid && axi_rsp.awready;
    assign w_fire  = axi_req.wvalid && axi_rsp.wready;
    assign done    = (state == READ && axi_rsp.rvalid) || (state == WRESP && axi_rsp.bvalid);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            ar_done <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    ar_done <= 1'b0;
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (pick.valid) begin
                        state <= pick.write ? WRITE : READ;
                    end
                end
                READ: begin
                    if (axi_req.arvalid && axi_rsp.arready) begin
                        ar_done <= 1'b1;
                    end
                    if (axi_rsp.rvalid) begin
                        state <= IDLE;
                    end
                end
                WRITE: begin
                    if (aw_fire) begin
                        aw_done <= 1'b1;
                    end
                    if (w_fire) begin
                        w_done <= 1'b1;
                    end
                    // Address and data may complete in either order
                    if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                        state <= WRESP;
                    end
                end
                WRESP: begin
                    if (axi_rsp.bvalid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            cur        <= pick;
            owner_data <= data_req.valid;
        end
    end

    assign axi_req.araddr  = cur.addr;
    assign axi_req.arvalid = state == READ && !ar_done;
    assign axi_req.rready  = state == READ;
    assign axi_req.awaddr  = cur.addr;
    assign axi_req.awvalid = state == WRITE && !aw_done;
    assign axi_req.wdata   = cur.wdata;
    assign axi_req.wstrb   = '1;
    assign axi_req.wvalid  = state == WRITE && !w_done;
    assign axi_req.bready  = state == WRESP;

    assign ifetch_rsp.done  = done && !owner_data;
    assign ifetch_rsp.rdata = axi_rsp.rdata;
    assign data_rsp.done    = done && owner_data;
    assign data_rsp.rdata   = axi_rsp.rdata;

endmodule

`default_nettype wire

//--- hdl/cpu_top.sv
`default_nettype none

`include "cpu_settings.svh"

module cpu_top
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;
(
    input  wire      clk,
    input  wire      reset,
    output axi_req_t axi_req,
    input  wire axi_rsp_t axi_rsp
);

    logic                 if_valid;
    logic                 if_ready;
    logic                 id_valid;
    logic                 id_ready;
    logic                 ex_valid;
    logic                 ex_ready;
    logic                 hold;
    logic                 redirect_valid;
    logic [`CPU_XLEN-1:0] redirect_pc;
    logic [`CPU_XLEN-1:0] inst;
    logic [`CPU_XLEN-1:0] inst_pc;
    mem_req_t             ifetch_req;
    mem_rsp_t             ifetch_rsp;
    mem_req_t             data_req;
    mem_rsp_t             data_rsp;
    reg_idx_t             rs1_index;
    reg_idx_t             rs2_index;
    logic [`CPU_XLEN-1:0] rs1_data;
    logic [`CPU_XLEN-1:0] rs2_data;
    logic [`CPU_XLEN-1:0] rs1_val;
    logic [`CPU_XLEN-1:0] rs2_val;
    rd_tag_t              ex_rd;
    rd_tag_t              me_rd;
    decoded_t             id_item;
    decoded_t             ex_item;
    logic [`CPU_XLEN-1:0] ex_result;
    logic [`CPU_XLEN-1:0] ex_store_data;
    logic [`CPU_XLEN-1:0] ex_target;
    logic                 ex_taken;
    logic                 we;
    reg_idx_t             rd_index;
    logic [`CPU_XLEN-1:0] rd_data;

    fetch_unit u_fetch (.*);

    decode_unit u_decode (.*);

    reg_file u_reg_file (.*);

    execute_unit u_execute (.*);

    mem_unit u_mem (.*);

    // Data side wins when both stages wait on the bus
    bus_arbiter u_arbiter (.*);

endmodule

`default_nettype wire

//--- dv/cpu_tb.sv
`default_nettype none

`include "cpu_settings.svh"

module cpu_tb
    import cpu_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS       = 256;
    localparam int PAT_WORDS       = 128;
    localparam int CYCLES_PER_WORD = 200;

    // Program image starts at word address zero
    localparam logic [`CPU_XLEN-1:0] PROG_BASE = 32'h0000_0000;

    logic     clk;
    logic     reset;
    axi_req_t axi_req;
    axi_rsp_t axi_rsp;

    logic [`CPU_XLEN-1:0] mem [MEM_WORDS];
    logic [`CPU_XLEN-1:0] pat [PAT_WORDS];
    logic [31:0]          lfsr;

    int   prog_words;
    int   store_count;
    int   store_idx;
    int   value_errors;
    int   other_errors;
    logic patterns_ok;
    logic first_read_seen;

    // Slave side state with one wait counter per channel
    int                   ar_cnt;
    int                   r_cnt;
    int                   aw_cnt;
    int                   w_cnt;
    int                   b_cnt;
    logic                 r_pending;
    logic                 aw_got;
    logic                 w_got;
    logic [`CPU_XLEN-1:0] rd_addr;
    logic [`CPU_XLEN-1:0] wr_addr;
    logic [`CPU_XLEN-1:0] wr_data;

    cpu_top DUT (
        .clk     (clk),
        .reset   (reset),
        .axi_req (axi_req),
        .axi_rsp (axi_rsp)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int random_delay();
        int d;
        d = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_step(lfsr);
            d    = (d << 1) | int'(lfsr[0]);
        end
        return d;
    endfunction

    task automatic flag_out_of_range(input string kind, input logic [`CPU_XLEN-1:0] addr);
        if (addr >= MEM_WORDS * 4) begin
            $display("%s address %h is outside the memory model", kind, addr);
            other_errors++;
        end
    endtask

    task automatic compare_store(input logic [`CPU_XLEN-1:0] addr,
                                 input logic [`CPU_XLEN-1:0] data);
        int base;
        if (store_idx >= store_count) begin
            $display("extra store of %h to address %h after the last expected store", data, addr);
            other_errors++;
        end else begin
            base = 2 + prog_words + 2 * store_idx;
            if (addr !== pat[base]) begin
                $display("error awaddr: store %0d got %h, expected %h",
                         store_idx, addr, pat[base]);
                value_errors++;
            end
            if (data !== pat[base + 1]) begin
                $display("error wdata: store %0d got %h, expected %h",
                         store_idx, data, pat[base + 1]);
                value_errors++;
            end
            store_idx++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset           = 1'b1;
        axi_rsp         = '0;
        lfsr            = 32'hf565;
        store_idx       = 0;
        value_errors    = 0;
        other_errors    = 0;
        patterns_ok     = 1'b0;
        first_read_seen = 1'b0;
        $readmemh("dv/cpu_patterns.txt", pat);
        prog_words  = int'(pat[0]);
        store_count = int'(pat[1]);
        if (prog_words <= 0 || store_count <= 0
                || 2 + prog_words + 2 * store_count > PAT_WORDS) begin
            $display("pattern file dv/cpu_patterns.txt is missing or has bad counts");
            other_errors++;
            $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
            $display("*** FAILED ***");
            $finish;
        end else begin
            // Address-dependent fill makes a stray read visible
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] = 32'(i * 4) ^ 32'ha5a5_a5a5;
            end
            for (int i = 0; i < prog_words; i++) begin
                mem[i] = pat[2 + i];
            end
            patterns_ok = 1'b1;
            repeat (5) @(posedge clk);
            reset <= 1'b0;
            wait (store_idx == store_count);
            // Short drain to catch stores after the last expected one
            repeat (20) @(posedge clk);
            $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
            if (value_errors == 0 && other_errors == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

    initial begin
        wait (patterns_ok);
        repeat (prog_words * CYCLES_PER_WORD) @(posedge clk);
        other_errors++;
        $display("timeout after %0d cycles with %0d of %0d expected stores seen",
                 prog_words * CYCLES_PER_WORD, store_idx, store_count);
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        $display("*** FAILED ***");
        $finish;
    end

    // AXI-Lite memory model
    always @(posedge clk) begin
        if (reset) begin
            axi_rsp   <= '0;
            r_pending <= 1'b0;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            ar_cnt    <= random_delay();
            r_cnt     <= random_delay();
            aw_cnt    <= random_delay();
            w_cnt     <= random_delay();
            b_cnt     <= random_delay();
        end else begin
            // Nothing may move before the first fetch from the reset PC
            if (!first_read_seen) begin
                if (axi_req.arvalid === 1'b1) begin
                    first_read_seen <= 1'b1;
                    if (axi_req.araddr !== PROG_BASE) begin
                        $display("error araddr: got %h, expected %h",
                                 axi_req.araddr, PROG_BASE);
                        value_errors++;
                    end
                end else if ({axi_req.arvalid, axi_req.rready, axi_req.awvalid,
                              axi_req.wvalid, axi_req.bready} !== 5'b0) begin
                    $display("AXI channel active or unknown before the first instruction read");
                    other_errors++;
                end
            end

            if (axi_req.arvalid && axi_rsp.arready) begin
                axi_rsp.arready <= 1'b0;
                rd_addr         <= axi_req.araddr;
                r_pending       <= 1'b1;
                ar_cnt          <= random_delay();
                flag_out_of_range("read", axi_req.araddr);
            end else if (axi_req.arvalid) begin
                if (ar_cnt == 0) begin
                    axi_rsp.arready <= 1'b1;
                end else begin
                    ar_cnt <= ar_cnt - 1;
                end
            end

            if (axi_rsp.rvalid && axi_req.rready) begin
                axi_rsp.rvalid <= 1'b0;
            end else if (r_pending && !axi_rsp.rvalid) begin
                if (r_cnt == 0) begin
                    axi_rsp.rvalid <= 1'b1;
                    axi_rsp.rdata  <= mem[rd_addr[9:2]];
                    r_pending      <= 1'b0;
                    r_cnt          <= random_delay();
                end else begin
                    r_cnt <= r_cnt - 1;
                end
            end

            if (axi_req.awvalid && axi_rsp.awready) begin
                axi_rsp.awready <= 1'b0;
                wr_addr         <= axi_req.awaddr;
                aw_got          <= 1'b1;
                aw_cnt          <= random_delay();
                flag_out_of_range("write", axi_req.awaddr);
            end else if (axi_req.awvalid) begin
                if (aw_cnt == 0) begin
                    axi_rsp.awready <= 1'b1;
                end else begin
                    aw_cnt <= aw_cnt - 1;
                end
            end

            if (axi_req.wvalid && axi_rsp.wready) begin
                axi_rsp.wready <= 1'b0;
                wr_data        <= axi_req.wdata;
                w_got          <= 1'b1;
                w_cnt          <= random_delay();
                if (axi_req.wstrb !== 4'hf) begin
                    $display("error wstrb: got %h, expected %h", axi_req.wstrb, 4'hf);
                    value_errors++;
                end
            end else if (axi_req.wvalid) begin
                if (w_cnt == 0) begin
                    axi_rsp.wready <= 1'b1;
                end else begin
                    w_cnt <= w_cnt - 1;
                end
            end

            // Response only once both address and data have arrived
            if (axi_rsp.bvalid && axi_req.bready) begin
                axi_rsp.bvalid <= 1'b0;
            end else if (aw_got && w_got && !axi_rsp.bvalid) begin
                if (b_cnt == 0) begin
                    axi_rsp.bvalid    <= 1'b1;
                    axi_rsp.bresp     <= '0;
                    aw_got            <= 1'b0;
                    w_got             <= 1'b0;
                    b_cnt             <= random_delay();
                    mem[wr_addr[9:2]] <= wr_data;
                    compare_store(wr_addr, wr_data);
                end else begin
                    b_cnt <= b_cnt - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/cpu_patterns.txt
// First line holds the program length and the number of expected stores
// Program words follow from address 0, then address and data of each store
00000023 0000000d
// Operands, with x1 as the store base 0x100
12345137 10000093 07f00193 ffd00213
// ADD SUB AND OR XOR SLT on x3 and x4
004182b3 40418333 0041f3b3 0041e433 0041c4b3 00322533
// Store the LUI and ALU results
0020a023 0050a223 0060a423 0070a623 0080a823 0090aa23 00a0ac23
// ADDI with a negative source and its store
01020593 00b0ae23
// Dependent chain on x12
00118613 00c60633 00364633 02c0a023
// Store, load back, store the loaded word
0290a223 0240a683 02d0a423
// Taken BEQ over two stores
00318663 0230a623 0240a623
// Not-taken BEQ, then JAL over one store
00418463 0230a623 0080076f 0240a823 02e0a823
// Idle loop
0000006f
// Expected stores
00000100 12345000
00000104 0000007c
00000108 00000082
0000010c 0000007d
00000110 ffffffff
00000114 ffffff82
00000118 00000001
0000011c 0000000d
00000120 0000017f
00000124 ffffff82
00000128 ffffff82
0000012c 0000007f
00000130 00000080

//--- tb.f
+incdir+include
hdl/cpu_isa_pkg.sv
hdl/cpu_bus_pkg.sv
hdl/reg_file.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/mem_unit.sv
hdl/bus_arbiter.sv
hdl/cpu_top.sv
dv/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

export_include_dirs:
  - include

sources:
  - hdl/cpu_isa_pkg.sv
  - hdl/cpu_bus_pkg.sv
  - hdl/reg_file.sv
  - hdl/fetch_unit.sv
  - hdl/decode_unit.sv
  - hdl/execute_unit.sv
  - hdl/mem_unit.sv
  - hdl/bus_arbiter.sv
  - hdl/cpu_top.sv
  - target: simulation
    files:
      - dv/cpu_tb.sv
